// ==== logic/ll_auto_sync.sv ====
`timescale 1ns/1ps

module ll_auto_sync (
  input  logic       clk_wr,
  input  logic       arst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       strobe_bit,
  output logic       marker_bit
);

  // Index 0 is the tx control, index 1 the rx control
  logic [1:0] online_in;
  logic [1:0] online_out;
  logic [7:0] delay_val [2];

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_val[0] = delay_xz_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////////////////////////
  // Delay FSMs
  ////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    lpif_pkg::sync_state_e state;
    logic [7:0]            cnt;

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        state <= lpif_pkg::offline;
        cnt   <= 8'd0;
      end else if (!online_in[ch]) begin
        // Dropping the control takes effect at once
        state <= lpif_pkg::offline;
        cnt   <= 8'd0;
      end else begin
        case (state)
          lpif_pkg::offline: begin
            if (delay_val[ch] == 8'd0) begin
              state <= lpif_pkg::online;
            end else begin
              state <= lpif_pkg::counting;
              cnt   <= delay_val[ch] - 8'd1;
            end
          end
          lpif_pkg::counting: begin
            if (cnt == 8'd0) begin
              state <= lpif_pkg::online;
            end else begin
              cnt <= cnt - 8'd1;
            end
          end
          lpif_pkg::online: state <= lpif_pkg::online;
          default:          state <= lpif_pkg::offline;
        endcase
      end
    end

    assign online_out[ch] = (state == lpif_pkg::online);
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

  // Strobe and marker only run once tx is up
  assign strobe_bit = online_out[0];
  assign marker_bit = online_out[0];

  // Delayed tx may only come up off a sampled request
  a_tx_rise_needs_online : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    $rose(tx_online_delay) |-> $past(tx_online)
  );

endmodule

// ==== logic/ll_lane_concat.sv ====
`timescale 1ns/1ps

module ll_lane_concat #(
  parameter int unsigned PHY_LANES = 4
) (
  input  logic                                        clk_wr,
  input  logic                                        arst_n,
  input  lpif_pkg::llink_word_t                       tx_word,
  input  logic                                        tx_online_delay,
  input  logic                                        strobe_bit,
  input  logic                                        marker_bit,
  input  logic [PHY_LANES*lpif_pkg::lane_width-1:0]   rx_phy,
  output logic [PHY_LANES*lpif_pkg::lane_width-1:0]   tx_phy,
  output lpif_pkg::llink_word_t                       rx_word,
  output logic                                        rx_word_ok,
  output logic [31:0]                                 rx_debug_status,
  output logic [31:0]                                 tx_debug_status
);

  localparam int unsigned word_width = $bits(lpif_pkg::llink_word_t);
  localparam int unsigned pad_width  = PHY_LANES * lpif_pkg::lane_payload;
  localparam int unsigned lw         = lpif_pkg::lane_width;
  localparam int unsigned pw         = lpif_pkg::lane_payload;

  logic [pad_width-1:0]              tx_pad;
  logic [pad_width-1:0]              rx_pad;
  logic [PHY_LANES*lw-1:0]           rx_q;
  logic [PHY_LANES-1:0]              rx_marks;
  logic                              mark_mismatch;
  logic [31:0]                       tx_cnt;
  logic [15:0]                       rx_cnt;
  logic [15:0]                       mis_cnt;

  ////////////////////////////////////////
  // Tx lanes
  ////////////////////////////////////////

  // Word zero padded up to the lane payload total
  always_comb begin
    tx_pad                   = '0;
    tx_pad[word_width-1:0]   = tx_word;
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (!tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      for (int i = 0; i < PHY_LANES; i++) begin
        tx_phy[i*lw +: lw] <= {marker_bit, tx_pad[i*pw +: pw], strobe_bit};
      end
    end
  end

  ////////////////////////////////////////
  // Rx lanes
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_phy;
    end
  end

  always_comb begin
    for (int i = 0; i < PHY_LANES; i++) begin
      rx_pad[i*pw +: pw] = rx_q[i*lw+1 +: pw];
      rx_marks[i]        = rx_q[i*lw+lw-1];
    end
  end

  assign rx_word       = rx_pad[word_width-1:0];
  // Strobe is checked on lane 0 only
  assign rx_word_ok    = rx_q[0] && (&rx_marks);
  assign mark_mismatch = (|rx_marks) && !(&rx_marks);

  ////////////////////////////////////////
  // Debug counters
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt  <= '0;
      rx_cnt  <= '0;
      mis_cnt <= '0;
    end else begin
      if (tx_online_delay && tx_word.valid) begin
        tx_cnt <= tx_cnt + 32'd1;
      end
      if (rx_word_ok && rx_word.valid) begin
        rx_cnt <= rx_cnt + 16'd1;
      end
      if (mark_mismatch) begin
        mis_cnt <= mis_cnt + 16'd1;
      end
    end
  end

  assign tx_debug_status = tx_cnt;
  assign rx_debug_status = {mis_cnt, rx_cnt};

  // Nothing leaves on the lanes unless the strobe was up the cycle before
  a_tx_quiet_offline : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    !$past(strobe_bit) |-> (tx_phy == '0)
  );

endmodule

// ==== logic/lpif_adapter_top.sv ====
`timescale 1ns/1ps

module lpif_adapter_top #(
  parameter int unsigned PHY_LANES = 4
) (
  input  logic                                        clk_wr,
  input  logic                                        arst_n,

  // Online controls and delays
  input  logic                                        tx_online,
  input  logic                                        rx_online,
  input  logic [7:0]                                  delay_x_value,
  input  logic [7:0]                                  delay_xz_value,

  // PHY lanes
  output logic [PHY_LANES*lpif_pkg::lane_width-1:0]   tx_phy,
  input  logic [PHY_LANES*lpif_pkg::lane_width-1:0]   rx_phy,

  // Upstream stream
  input  lpif_pkg::lpif_state_e                       ustrm_state,
  input  logic [1:0]                                  ustrm_protid,
  input  logic [lpif_pkg::data_width-1:0]             ustrm_data,
  input  logic [lpif_pkg::bstart_width-1:0]           ustrm_bstart,
  input  logic [lpif_pkg::bvalid_width-1:0]           ustrm_bvalid,
  input  logic                                        ustrm_valid,

  // Downstream stream
  output lpif_pkg::lpif_state_e                       dstrm_state,
  output logic [1:0]                                  dstrm_protid,
  output logic [lpif_pkg::data_width-1:0]             dstrm_data,
  output logic [lpif_pkg::bstart_width-1:0]           dstrm_bstart,
  output logic [lpif_pkg::bvalid_width-1:0]           dstrm_bvalid,
  output logic                                        dstrm_valid,

  output logic [31:0]                                 rx_debug_status,
  output logic [31:0]                                 tx_debug_status
);

  lpif_stream_if ustrm ();
  lpif_stream_if dstrm ();

  lpif_pkg::llink_word_t tx_word;
  lpif_pkg::llink_word_t rx_word;
  logic                  rx_word_ok;
  logic                  tx_online_delay;
  logic                  rx_online_delay;
  logic                  strobe_bit;
  logic                  marker_bit;

  ////////////////////////////////////////
  // Pins to streams
  ////////////////////////////////////////

  assign ustrm.state  = ustrm_state;
  assign ustrm.protid = ustrm_protid;
  assign ustrm.data   = ustrm_data;
  assign ustrm.bstart = ustrm_bstart;
  assign ustrm.bvalid = ustrm_bvalid;
  assign ustrm.valid  = ustrm_valid;

  assign dstrm_state  = dstrm.state;
  assign dstrm_protid = dstrm.protid;
  assign dstrm_data   = dstrm.data;
  assign dstrm_bstart = dstrm.bstart;
  assign dstrm_bvalid = dstrm.bvalid;
  assign dstrm_valid  = dstrm.valid;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  ll_auto_sync i_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .strobe_bit      (strobe_bit),
    .marker_bit      (marker_bit)
  );

  lpif_stream_pack i_stream_pack (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .ustrm           (ustrm.snk),
    .dstrm           (dstrm.src),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .rx_online_delay (rx_online_delay)
  );

  ll_lane_concat #(
    .PHY_LANES (PHY_LANES)
  ) i_lane_concat (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_word         (tx_word),
    .tx_online_delay (tx_online_delay),
    .strobe_bit      (strobe_bit),
    .marker_bit      (marker_bit),
    .rx_phy          (rx_phy),
    .tx_phy          (tx_phy),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .rx_debug_status (rx_debug_status),
    .tx_debug_status (tx_debug_status)
  );

endmodule

// ==== logic/lpif_pkg.sv ====
package lpif_pkg;

  ////////////////////////////////////////
  // Lane and stream widths
  ////////////////////////////////////////

  localparam int unsigned lane_width   = 40;
  // Bit 0 is the strobe slot and bit 39 the marker
  localparam int unsigned lane_payload = 38;

  localparam int unsigned data_width   = 64;
  localparam int unsigned bvalid_width = data_width / 8;
  localparam int unsigned bstart_width = 3;

  ////////////////////////////////////////
  // States
  ////////////////////////////////////////

  // LPIF link state as carried on the stream
  typedef enum logic [3:0] {
    reset      = 4'h0,
    active     = 4'h1,
    idle       = 4'h2,
    l1         = 4'h4,
    l2         = 4'h5,
    link_error = 4'ha,
    retrain    = 4'hb
  } lpif_state_e;

  // Auto-sync phase of one online control
  typedef enum logic [1:0] {
    offline  = 2'd0,
    counting = 2'd1,
    online   = 2'd2
  } sync_state_e;

  // One stream beat flattened for the lanes, 82 bits
  typedef struct packed {
    lpif_state_e               state;
    logic [1:0]                protid;
    logic [data_width-1:0]     data;
    logic [bstart_width-1:0]   bstart;
    logic [bvalid_width-1:0]   bvalid;
    logic                      valid;
  } llink_word_t;

endpackage

// ==== logic/lpif_stream_if.sv ====
`timescale 1ns/1ps

interface lpif_stream_if;

  lpif_pkg::lpif_state_e                 state;
  logic [1:0]                            protid;
  logic [lpif_pkg::data_width-1:0]       data;
  logic [lpif_pkg::bstart_width-1:0]     bstart;
  logic [lpif_pkg::bvalid_width-1:0]     bvalid;
  logic                                  valid;

  // Side that produces the beats
  modport src (
    output state, protid, data, bstart, bvalid, valid
  );

  // Side that consumes the beats
  modport snk (
    input  state, protid, data, bstart, bvalid, valid
  );

endinterface

// ==== logic/lpif_stream_pack.sv ====
`timescale 1ns/1ps

module lpif_stream_pack (
  input  logic                  clk_wr,
  input  logic                  arst_n,
  lpif_stream_if.snk            ustrm,
  lpif_stream_if.src            dstrm,
  output lpif_pkg::llink_word_t tx_word,
  input  lpif_pkg::llink_word_t rx_word,
  input  logic                  rx_word_ok,
  input  logic                  rx_online_delay
);

  logic dstrm_keep;

  ////////////////////////////////////////
  // Upstream packing
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_word <= '0;
    end else begin
      tx_word.state  <= ustrm.state;
      tx_word.protid <= ustrm.protid;
      tx_word.data   <= ustrm.data;
      tx_word.bstart <= ustrm.bstart;
      tx_word.bvalid <= ustrm.bvalid;
      tx_word.valid  <= ustrm.valid;
    end
  end

  ////////////////////////////////////////
  // Downstream unpacking
  ////////////////////////////////////////

  // Needs a clean word from the lanes and rx up
  assign dstrm_keep = rx_word.valid && rx_word_ok && rx_online_delay;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dstrm.valid <= 1'b0;
      dstrm.state <= lpif_pkg::reset;
    end else begin
      dstrm.valid <= dstrm_keep;
      dstrm.state <= dstrm_keep ? rx_word.state : lpif_pkg::reset;
    end
  end

  // Payload fields follow the word every cycle
  always_ff @(posedge clk_wr) begin
    dstrm.protid <= rx_word.protid;
    dstrm.data   <= rx_word.data;
    dstrm.bstart <= rx_word.bstart;
    dstrm.bvalid <= rx_word.bvalid;
  end

  // Downstream beats only come out while rx is online
  a_dstrm_needs_rx_online : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    dstrm.valid |-> $past(rx_online_delay)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module lpif_adapter_tb -o lpif_sim \
  && ./obj_dir/lpif_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== testbench/lpif_adapter_tb.sv ====
`timescale 1ns/1ps

module lpif_adapter_tb;

  localparam int unsigned phy_lanes = 4;
  localparam int unsigned lw        = lpif_pkg::lane_width;

  logic                        clk;
  logic                        arst_n;
  logic                        tx_online;
  logic                        rx_online;
  logic [7:0]                  delay_x_value;
  logic [7:0]                  delay_xz_value;
  logic [phy_lanes*lw-1:0]     tx_phy;
  logic [phy_lanes*lw-1:0]     rx_phy;
  lpif_pkg::lpif_state_e       ustrm_state;
  logic [1:0]                  ustrm_protid;
  logic [lpif_pkg::data_width-1:0]   ustrm_data;
  logic [lpif_pkg::bstart_width-1:0] ustrm_bstart;
  logic [lpif_pkg::bvalid_width-1:0] ustrm_bvalid;
  logic                        ustrm_valid;
  lpif_pkg::lpif_state_e       dstrm_state;
  logic [1:0]                  dstrm_protid;
  logic [lpif_pkg::data_width-1:0]   dstrm_data;
  logic [lpif_pkg::bstart_width-1:0] dstrm_bstart;
  logic [lpif_pkg::bvalid_width-1:0] dstrm_bvalid;
  logic                        dstrm_valid;
  logic [31:0]                 rx_debug_status;
  logic [31:0]                 tx_debug_status;
  logic                        fault_on;

  // Expected link conditions seen by the reference
  bit tx_up;
  bit rx_up;
  bit lane_fault;
  bit push_en;
  bit timed_out;
  lpif_pkg::llink_word_t exp_q[$];
  int due_q[$];
  int cyc;
  int n_checks;
  int n_errors;
  int n_tests;
  int n_failed;

  lpif_adapter_top #(.PHY_LANES(phy_lanes)) i_dut (
    .clk_wr(clk), .arst_n(arst_n), .tx_online(tx_online), .rx_online(rx_online),
    .delay_x_value(delay_x_value), .delay_xz_value(delay_xz_value),
    .tx_phy(tx_phy), .rx_phy(rx_phy),
    .ustrm_state(ustrm_state), .ustrm_protid(ustrm_protid), .ustrm_data(ustrm_data),
    .ustrm_bstart(ustrm_bstart), .ustrm_bvalid(ustrm_bvalid), .ustrm_valid(ustrm_valid),
    .dstrm_state(dstrm_state), .dstrm_protid(dstrm_protid), .dstrm_data(dstrm_data),
    .dstrm_bstart(dstrm_bstart), .dstrm_bvalid(dstrm_bvalid), .dstrm_valid(dstrm_valid),
    .rx_debug_status(rx_debug_status), .tx_debug_status(tx_debug_status)
  );

  // External loopback that can hold the lane 1 marker low
  always_comb begin
    rx_phy = tx_phy;
    if (fault_on) begin
      rx_phy[lw + lw - 1] = 1'b0;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference and checks
  ////////////////////////////////////////

  // Beat as it should leave dstrm after the loopback
  function automatic lpif_pkg::llink_word_t loop_model(input lpif_pkg::llink_word_t beat,
                                                       input bit tx_ok, input bit rx_ok,
                                                       input bit fault);
    lpif_pkg::llink_word_t res;
    res = beat;
    if (!(beat.valid && tx_ok && rx_ok && !fault)) begin
      res.valid = 1'b0;
      res.state = lpif_pkg::reset;
    end
    return res;
  endfunction

  function automatic lpif_pkg::lpif_state_e pick_state(input int idx);
    case (idx)
      0: return lpif_pkg::reset;
      1: return lpif_pkg::active;
      2: return lpif_pkg::idle;
      3: return lpif_pkg::l1;
      4: return lpif_pkg::l2;
      5: return lpif_pkg::link_error;
      default: return lpif_pkg::retrain;
    endcase
  endfunction

  task automatic check_word(input lpif_pkg::llink_word_t exp, input lpif_pkg::llink_word_t act);
    bit bad;
    n_checks++;
    if (exp.valid) begin
      bad = (act !== exp);
    end else begin
      bad = (act.valid !== 1'b0) || (act.state !== lpif_pkg::reset);
    end
    if (bad) begin
      n_errors++;
      $display("Error at %0t: dstrm beat expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, what, exp, act);
    end
  endtask

  // Every beat is due on dstrm four cycles after it is driven
  always @(negedge clk) begin
    lpif_pkg::llink_word_t obs;
    lpif_pkg::llink_word_t beat;
    cyc = cyc + 1;
    obs.state  = dstrm_state;
    obs.protid = dstrm_protid;
    obs.data   = dstrm_data;
    obs.bstart = dstrm_bstart;
    obs.bvalid = dstrm_bvalid;
    obs.valid  = dstrm_valid;
    if (exp_q.size() != 0 && due_q[0] == cyc) begin
      check_word(exp_q.pop_front(), obs);
      void'(due_q.pop_front());
    end
    if (push_en) begin
      beat.state  = ustrm_state;
      beat.protid = ustrm_protid;
      beat.data   = ustrm_data;
      beat.bstart = ustrm_bstart;
      beat.bvalid = ustrm_bvalid;
      beat.valid  = ustrm_valid;
      exp_q.push_back(loop_model(beat, tx_up, rx_up, lane_fault));
      due_q.push_back(cyc + 4);
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic send_burst(input int n, output int n_valid);
    bit v;
    n_valid = 0;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      v = ($urandom_range(3, 0) != 0);
      ustrm_state  <= pick_state(int'($urandom_range(6, 0)));
      ustrm_protid <= 2'($urandom);
      ustrm_data   <= {$urandom, $urandom};
      ustrm_bstart <= 3'($urandom);
      ustrm_bvalid <= 8'($urandom);
      ustrm_valid  <= v;
      push_en      <= 1'b1;
      if (v) begin
        n_valid++;
      end
    end
    @(posedge clk);
    ustrm_valid <= 1'b0;
    push_en     <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      timed_out = 1'b1;
      $display("Timeout: expected beats still pending on dstrm after 50 cycles");
    end
  endtask

  task automatic wait_tx_online();
    int n;
    n = 0;
    while (!i_dut.tx_online_delay && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!i_dut.tx_online_delay) begin
      timed_out = 1'b1;
      $display("Timeout: delayed tx online did not come up within 50 cycles");
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    n_tests++;
    if (n_errors == err_before && !timed_out) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s: FAILED", n_tests, name);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main_seq
    int err0;
    int n_valid;
    int n;
    int tx_n;
    int rx_n;
    int stb_n;
    int fault_start;
    int fault_len;
    logic [31:0] tx_base;
    logic [31:0] rx_base;
    void'($urandom(70));
    arst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_x_value = 8'd5;
    delay_xz_value = 8'd5;
    ustrm_state = lpif_pkg::reset;
    ustrm_protid = 2'd0;
    ustrm_data = '0;
    ustrm_bstart = '0;
    ustrm_bvalid = '0;
    ustrm_valid = 1'b0;
    fault_on = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // Quiet outputs after reset
    err0 = n_errors;
    @(negedge clk);
    check_count("dstrm_valid", 32'd0, {31'd0, dstrm_valid});
    check_count("tx lane bits set", 32'd0, $countones(tx_phy));
    check_count("tx_debug_status", 32'd0, tx_debug_status);
    check_count("rx_debug_status", 32'd0, rx_debug_status);
    end_test("reset state", err0);

    // Online delays counted from the first sampling edge
    err0 = n_errors;
    @(posedge clk);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    tx_n = 0;
    rx_n = 0;
    stb_n = 0;
    n = 0;
    while ((tx_n == 0 || rx_n == 0 || stb_n == 0) && n < 50) begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (tx_n == 0 && i_dut.tx_online_delay) tx_n = n;
      if (rx_n == 0 && i_dut.rx_online_delay) rx_n = n;
      if (stb_n == 0 && i_dut.strobe_bit) stb_n = n;
    end
    if (tx_n == 0 || rx_n == 0 || stb_n == 0) begin
      timed_out = 1'b1;
      $display("Timeout: online delay or strobe did not rise within 50 cycles");
    end else begin
      check_count("tx online delay", {24'd0, delay_xz_value}, tx_n - 1);
      check_count("rx online delay", {24'd0, delay_x_value}, rx_n - 1);
      check_count("strobe delay", {24'd0, delay_xz_value}, stb_n - 1);
    end
    tx_up = 1'b1;
    rx_up = 1'b1;
    end_test("online delay", err0);

    if (!timed_out) begin
      err0 = n_errors;
      send_burst(40, n_valid);
      wait_drain();
      end_test("loopback beats", err0);
    end

    // Beats while tx is offline must vanish
    if (!timed_out) begin
      err0 = n_errors;
      tx_base = tx_debug_status;
      rx_base = rx_debug_status;
      @(posedge clk);
      tx_online <= 1'b0;
      tx_up = 1'b0;
      send_burst(20, n_valid);
      wait_drain();
      check_count("tx words while offline", tx_base, tx_debug_status);
      check_count("rx words while offline", rx_base, rx_debug_status);
      @(posedge clk);
      tx_online <= 1'b1;
      wait_tx_online();
      tx_up = 1'b1;
      end_test("tx offline", err0);
    end

    if (!timed_out) begin
      err0 = n_errors;
      tx_base = tx_debug_status;
      rx_base = rx_debug_status;
      send_burst(60, n_valid);
      wait_drain();
      check_count("tx word count", n_valid, tx_debug_status - tx_base);
      check_count("rx word count", n_valid, {16'd0, rx_debug_status[15:0] - rx_base[15:0]});
      check_count("marker mismatches", 32'd0,
                  {16'd0, rx_debug_status[31:16] - rx_base[31:16]});
      end_test("word counters", err0);
    end

    // Lane 1 marker held low on the loopback
    if (!timed_out) begin
      err0 = n_errors;
      rx_base = rx_debug_status;
      @(posedge clk);
      fault_on <= 1'b1;
      lane_fault = 1'b1;
      fault_start = cyc;
      send_burst(20, n_valid);
      wait_drain();
      fault_on <= 1'b0;
      fault_len = cyc - fault_start;
      // Counter trails the lanes by two edges
      repeat (3) @(posedge clk);
      lane_fault = 1'b0;
      check_count("marker mismatches", fault_len,
                  {16'd0, rx_debug_status[31:16] - rx_base[31:16]});
      check_count("rx words under fault", 32'd0,
                  {16'd0, rx_debug_status[15:0] - rx_base[15:0]});
      end_test("marker fault", err0);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d, timeout %0d",
             n_tests, n_failed, n_checks, n_errors, timed_out);
    if (n_errors == 0 && n_failed == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/lpif_pkg.sv
logic/lpif_stream_if.sv
logic/ll_auto_sync.sv
logic/lpif_stream_pack.sv
logic/ll_lane_concat.sv
logic/lpif_adapter_top.sv
testbench/lpif_adapter_tb.sv
